// File: filelist.f
rtl/rv_retire_pkg.sv
rtl/load_align.sv
rtl/trap_select.sv
rtl/retire.sv
rtl/rv_retire_top.sv
verif/tb_rv_retire.sv

// File: rtl/load_align.sv
/* Load alignment
 * Picks the byte or half lane of the memory read word
 * and sign- or zero-extends it to a full word
 */
`timescale 1ns/100ps
`default_nettype none

module load_align (
    input  rv_retire_pkg::op_t   op,            // Retiring operation
    input  logic [1:0]           addr_low,      // Byte offset of the load address
    input  rv_retire_pkg::word_t data_in,       // Raw word from memory
    output rv_retire_pkg::word_t load_data      // Aligned value for write-back
);
    import rv_retire_pkg::*;

    logic [7:0]  byte_lane;                     // Selected byte
    logic [15:0] half_lane;                     // Selected half
    logic        sign_ext;                      // Signed load flavour

    // Byte lane follows the full offset
    always_comb begin
        case (addr_low)
            2'b00:   byte_lane = data_in[7:0];
            2'b01:   byte_lane = data_in[15:8];
            2'b10:   byte_lane = data_in[23:16];
            default: byte_lane = data_in[31:24];
        endcase
    end

    assign half_lane = addr_low[1] ? data_in[31:16] : data_in[15:0];  // Upper or lower half
    assign sign_ext  = (op == OP_LB) || (op == OP_LH);               // LBU/LHU zero-extend

    always_comb begin
        case (op)
            OP_LB, OP_LBU: begin
                load_data = {{24{sign_ext & byte_lane[7]}}, byte_lane};   // Replicate MSB if signed
            end
            OP_LH, OP_LHU: begin
                load_data = {{16{sign_ext & half_lane[15]}}, half_lane};
            end
            default: begin
                load_data = data_in;            // LW and non-load ops pass the word
            end
        endcase
    end

    // Execute never issues a half load on an odd byte address
    always_comb begin
        assert final (!(is_half_load(op) && addr_low[0]))
            else $error("load_align: halfword load with odd address offset %0d", addr_low);
    end

endmodule

`default_nettype wire

// File: rtl/retire.sv
/* Retire stage
 * Tag register and kill decision, write-back select,
 * jump and store gating, tag advance on control-flow events
 */
`timescale 1ns/100ps
`default_nettype none

module retire #(
    parameter int TAG_WIDTH = rv_retire_pkg::TAG_WIDTH_DEFAULT
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      exception,          // Illegal instruction flag
    input  rv_retire_pkg::op_t        op,                 // Retiring operation
    input  rv_retire_pkg::word_t      result0,            // ALU result or store data
    input  rv_retire_pkg::word_t      result1,            // Jump target or memory address
    input  logic                      jump,               // Branch unit decided to jump
    input  logic                      we,                 // Instruction writes rd
    input  logic [TAG_WIDTH-1:0]      tag_in,             // Tag issued with the instruction
    input  rv_retire_pkg::byte_en_t   we_mem_in,          // Store byte enables
    input  rv_retire_pkg::word_t      data_in,            // Memory read word
    input  logic                      interrupt_pending,
    output logic                      reg_we,             // Register bank write enable
    output rv_retire_pkg::word_t      wr_data,            // Register bank write data
    output logic                      jump_out,           // Redirect to fetch
    output rv_retire_pkg::word_t      new_pc,             // Redirect target
    output rv_retire_pkg::word_t      write_address,      // Store address
    output rv_retire_pkg::word_t      data_out,           // Store data
    output rv_retire_pkg::byte_en_t   write,              // Store byte enables to memory
    output logic [TAG_WIDTH-1:0]      curr_retire_tag,    // Tag expected from issue
    output logic                      raise_exception,
    output rv_retire_pkg::exc_code_t  exception_code,
    output logic                      machine_return,
    output logic                      interrupt_ack
);
    import rv_retire_pkg::*;

    logic [TAG_WIDTH-1:0] curr_tag;             // Current path tag
    logic                 killed;               // Instruction is from a flushed path
    logic                 live;                 // Instruction commits
    word_t                load_data;            // Aligned load value
    logic                 store_live;           // Store commits this cycle
    logic                 advance;              // Any taken control-flow event

    assign killed = (tag_in != curr_tag);       // Stale tag means wrong path
    assign live   = ~killed;

    load_align i_load_align (
        .op        (op),
        .addr_low  (result1[1:0]),              // Byte offset of the load address
        .data_in   (data_in),
        .load_data (load_data)
    );

    trap_select i_trap_select (
        .live              (live),
        .exception         (exception),
        .op                (op),
        .jump              (jump),
        .interrupt_pending (interrupt_pending),
        .raise_exception   (raise_exception),
        .exception_code    (exception_code),
        .machine_return    (machine_return),
        .interrupt_ack     (interrupt_ack)
    );

    // Write-back
    assign wr_data = is_load(op) ? load_data : result0;
    assign reg_we  = live & we;                 // Killed instructions never write rd

    // Redirect to fetch
    assign jump_out = live & jump;
    assign new_pc   = jump_out ? result1 : '0;

    // Store port idles at all zero
    assign store_live    = live & (we_mem_in != '0);
    assign write         = store_live ? we_mem_in : '0;
    assign write_address = store_live ? result1 : '0;
    assign data_out      = store_live ? result0 : '0;

    // Trap outputs are already gated by live inside trap_select
    assign advance = jump_out | raise_exception | machine_return | interrupt_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            curr_tag <= '0;
        end else if (advance) begin
            curr_tag <= curr_tag + 1'b1;        // Wraps modulo 2^TAG_WIDTH
        end
    end

    assign curr_retire_tag = curr_tag;

    // A wrong-path instruction must not redirect fetch
    assert property (@(posedge clk) disable iff (reset) killed |-> !jump_out)
        else $error("retire: jump_out raised for a killed instruction");

    // Nor touch memory
    assert property (@(posedge clk) disable iff (reset)
        killed |-> (write == '0) && (write_address == '0) && (data_out == '0))
        else $error("retire: store issued for a killed instruction");

    // Killed instructions leave the tag alone even when they carry a trap
    assert property (@(posedge clk) disable iff (reset) killed |=> curr_tag == $past(curr_tag))
        else $error("retire: tag advanced after a killed instruction");

endmodule

`default_nettype wire

// File: rtl/rv_retire_pkg.sv
/* Shared retire-stage definitions
 * Word and byte-enable types, mcause exception codes,
 * retiring-operation encoding and the load-op helpers
 */
`default_nettype none

package rv_retire_pkg;

    parameter int TAG_WIDTH_DEFAULT = 4;        // Tag width unless the top overrides it

    typedef logic [31:0] word_t;                // Data or address word
    typedef logic [3:0]  byte_en_t;             // One enable per byte lane of a store

    // Machine-mode trap causes as written to mcause
    typedef enum logic [3:0] {
        EXC_NONE       = 4'd0,                  // No trap this cycle
        EXC_ILLEGAL    = 4'd2,                  // Illegal instruction
        EXC_BREAKPOINT = 4'd3,                  // ebreak
        EXC_ECALL_M    = 4'd11                  // ecall from M-mode
    } exc_code_t;

    // Operations that retire has to tell apart
    typedef enum logic [3:0] {
        OP_OTHER  = 4'd0,                       // ALU, branch, jump, CSR
        OP_LB     = 4'd1,                       // Signed byte load
        OP_LBU    = 4'd2,                       // Unsigned byte load
        OP_LH     = 4'd3,                       // Signed half load
        OP_LHU    = 4'd4,                       // Unsigned half load
        OP_LW     = 4'd5,                       // Word load
        OP_STORE  = 4'd6,                       // Any store width
        OP_ECALL  = 4'd7,
        OP_EBREAK = 4'd8,
        OP_MRET   = 4'd9
    } op_t;

    // True for every load width
    function automatic logic is_load(op_t op);
        return op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
    endfunction

    // True for the two halfword loads
    function automatic logic is_half_load(op_t op);
        return op inside {OP_LH, OP_LHU};
    endfunction

endpackage

`default_nettype wire

// File: rtl/rv_retire_top.sv
/* Retire top level
 * Wraps the retire stage and exposes the pipeline-side ports
 */
`timescale 1ns/100ps
`default_nettype none

module rv_retire_top #(
    parameter int TAG_WIDTH = rv_retire_pkg::TAG_WIDTH_DEFAULT   // Tag width for the whole stage
) (
    input  logic                      clk,
    input  logic                      reset,
    // From execute
    input  logic                      exception,
    input  rv_retire_pkg::op_t        op,
    input  rv_retire_pkg::word_t      result0,
    input  rv_retire_pkg::word_t      result1,
    input  logic                      jump,
    input  logic                      we,
    input  logic [TAG_WIDTH-1:0]      tag_in,
    input  rv_retire_pkg::byte_en_t   we_mem_in,
    // From memory and CSR file
    input  rv_retire_pkg::word_t      data_in,
    input  logic                      interrupt_pending,
    // To register bank
    output logic                      reg_we,
    output rv_retire_pkg::word_t      wr_data,
    // To fetch
    output logic                      jump_out,
    output rv_retire_pkg::word_t      new_pc,
    // To memory
    output rv_retire_pkg::word_t      write_address,
    output rv_retire_pkg::word_t      data_out,
    output rv_retire_pkg::byte_en_t   write,
    // To issue and CSR file
    output logic [TAG_WIDTH-1:0]      curr_retire_tag,
    output logic                      raise_exception,
    output rv_retire_pkg::exc_code_t  exception_code,
    output logic                      machine_return,
    output logic                      interrupt_ack
);

    retire #(
        .TAG_WIDTH (TAG_WIDTH)
    ) i_retire (
        .clk               (clk),
        .reset             (reset),
        .exception         (exception),
        .op                (op),
        .result0           (result0),
        .result1           (result1),
        .jump              (jump),
        .we                (we),
        .tag_in            (tag_in),
        .we_mem_in         (we_mem_in),
        .data_in           (data_in),
        .interrupt_pending (interrupt_pending),
        .reg_we            (reg_we),
        .wr_data           (wr_data),
        .jump_out          (jump_out),
        .new_pc            (new_pc),
        .write_address     (write_address),
        .data_out          (data_out),
        .write             (write),
        .curr_retire_tag   (curr_retire_tag),
        .raise_exception   (raise_exception),
        .exception_code    (exception_code),
        .machine_return    (machine_return),
        .interrupt_ack     (interrupt_ack)
    );

endmodule

`default_nettype wire

// File: rtl/trap_select.sv
/* Trap priority
 * Turns illegal instruction, ecall, ebreak, mret and interrupt
 * into at most one trap event with its cause code
 */
`timescale 1ns/100ps
`default_nettype none

module trap_select (
    input  logic                      live,              // Instruction tag matches
    input  logic                      exception,         // Illegal instruction from decode
    input  rv_retire_pkg::op_t        op,                // Retiring operation
    input  logic                      jump,              // Taken jump this cycle
    input  logic                      interrupt_pending, // Enabled interrupt waiting
    output logic                      raise_exception,   // Synchronous exception to CSR file
    output rv_retire_pkg::exc_code_t  exception_code,    // mcause value for the exception
    output logic                      machine_return,    // mret retires
    output logic                      interrupt_ack      // Interrupt taken on this instruction
);
    import rv_retire_pkg::*;

    always_comb begin
        raise_exception = 1'b0;                 // Defaults hold when nothing fires
        exception_code  = EXC_NONE;
        machine_return  = 1'b0;
        interrupt_ack   = 1'b0;
        if (live) begin
            if (exception) begin
                raise_exception = 1'b1;         // Illegal beats everything
                exception_code  = EXC_ILLEGAL;
            end else if (op == OP_ECALL) begin
                raise_exception = 1'b1;
                exception_code  = EXC_ECALL_M;
            end else if (op == OP_EBREAK) begin
                raise_exception = 1'b1;
                exception_code  = EXC_BREAKPOINT;
            end else if (op == OP_MRET) begin
                machine_return = 1'b1;          // Return to mepc
            end else if (interrupt_pending && !jump) begin
                interrupt_ack = 1'b1;           // Never on a taken jump whose target would be lost
            end
        end
    end

    // One event per retiring instruction
    always_comb begin
        assert final ($onehot0({raise_exception, machine_return, interrupt_ack}))
            else $error("trap_select: more than one trap event raised");
    end

    // CSR file only samples the cause with raise_exception
    always_comb begin
        assert final (raise_exception || (exception_code == EXC_NONE))
            else $error("trap_select: cause %0d without raise_exception", exception_code);
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the retire stage testbench with Verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_retire \
    -f filelist.f -o sim_rv_retire > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_rv_retire > sim.log 2>&1
cat sim.log
grep -qF '*** PASSED ***' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: verif/retire_vectors.txt
# exception op result0 result1 jump we tag_in we_mem_in data_in interrupt_pending, then expected:
# reg_we wr_data jump_out new_pc write write_address data_out raise_exception code mret iack tag
0 0 00000000 00000000 0 0 0 0 00000000 0  0 00000000 0 00000000 0 00000000 00000000 0 0 0 0 0
0 0 12345678 00000000 0 1 0 0 00000000 0  1 12345678 0 00000000 0 00000000 00000000 0 0 0 0 0
0 6 cafebabe 00001000 0 0 0 f 00000000 0  0 cafebabe 0 00000000 f 00001000 cafebabe 0 0 0 0 0
0 6 000000aa 00001001 0 0 0 2 00000000 0  0 000000aa 0 00000000 2 00001001 000000aa 0 0 0 0 0
0 5 00000000 00002000 0 1 0 0 deadbeef 0  1 deadbeef 0 00000000 0 00000000 00000000 0 0 0 0 0
0 0 00000104 00000400 1 1 0 0 00000000 0  1 00000104 1 00000400 0 00000000 00000000 0 0 0 0 0
0 0 11111111 00000800 1 1 0 f 00000000 0  0 11111111 0 00000000 0 00000000 00000000 0 0 0 0 1
1 7 00000000 00000000 0 0 0 0 00000000 1  0 00000000 0 00000000 0 00000000 00000000 0 0 0 0 1
0 1 00000000 00000000 0 1 3 0 00000080 0  0 ffffff80 0 00000000 0 00000000 00000000 0 0 0 0 1
0 0 00000055 00000000 0 1 1 0 00000000 0  1 00000055 0 00000000 0 00000000 00000000 0 0 0 0 1
1 7 00000000 00000000 0 0 1 0 00000000 1  0 00000000 0 00000000 0 00000000 00000000 1 2 0 0 1
0 7 00000000 00000000 0 0 2 0 00000000 1  0 00000000 0 00000000 0 00000000 00000000 1 b 0 0 2
0 8 00000000 00000000 0 0 3 0 00000000 1  0 00000000 0 00000000 0 00000000 00000000 1 3 0 0 3
0 9 00000000 00000000 0 0 4 0 00000000 1  0 00000000 0 00000000 0 00000000 00000000 0 0 1 0 4
0 0 00000000 00000200 1 0 5 0 00000000 1  0 00000000 1 00000200 0 00000000 00000000 0 0 0 0 5
0 0 00000000 00000000 0 0 6 0 00000000 1  0 00000000 0 00000000 0 00000000 00000000 0 0 0 1 6
1 0 00000000 00000300 1 0 7 0 00000000 0  0 00000000 1 00000300 0 00000000 00000000 1 2 0 0 7
0 0 00000000 00000000 0 0 8 0 00000000 0  0 00000000 0 00000000 0 00000000 00000000 0 0 0 0 8
0 1 00000000 00003000 0 1 8 0 81f27e93 0  1 ffffff93 0 00000000 0 00000000 00000000 0 0 0 0 8
0 1 00000000 00003001 0 1 8 0 81f27e93 0  1 0000007e 0 00000000 0 00000000 00000000 0 0 0 0 8
0 1 00000000 00003002 0 1 8 0 81f27e93 0  1 fffffff2 0 00000000 0 00000000 00000000 0 0 0 0 8
0 1 00000000 00003003 0 1 8 0 81f27e93 0  1 ffffff81 0 00000000 0 00000000 00000000 0 0 0 0 8
0 2 00000000 00003000 0 1 8 0 81f27e93 0  1 00000093 0 00000000 0 00000000 00000000 0 0 0 0 8
0 2 00000000 00003001 0 1 8 0 81f27e93 0  1 0000007e 0 00000000 0 00000000 00000000 0 0 0 0 8
0 2 00000000 00003002 0 1 8 0 81f27e93 0  1 000000f2 0 00000000 0 00000000 00000000 0 0 0 0 8
0 2 00000000 00003003 0 1 8 0 81f27e93 0  1 00000081 0 00000000 0 00000000 00000000 0 0 0 0 8
0 3 00000000 00003000 0 1 8 0 81f27e93 0  1 00007e93 0 00000000 0 00000000 00000000 0 0 0 0 8
0 3 00000000 00003002 0 1 8 0 81f27e93 0  1 ffff81f2 0 00000000 0 00000000 00000000 0 0 0 0 8
0 4 00000000 00003000 0 1 8 0 81f27e93 0  1 00007e93 0 00000000 0 00000000 00000000 0 0 0 0 8
0 4 00000000 00003002 0 1 8 0 81f27e93 0  1 000081f2 0 00000000 0 00000000 00000000 0 0 0 0 8
0 5 00000000 00003000 0 1 8 0 81f27e93 0  1 81f27e93 0 00000000 0 00000000 00000000 0 0 0 0 8
0 0 00000000 00000800 1 0 8 0 00000000 0  0 00000000 1 00000800 0 00000000 00000000 0 0 0 0 8
0 0 00000000 00000900 1 0 9 0 00000000 0  0 00000000 1 00000900 0 00000000 00000000 0 0 0 0 9
0 0 00000000 00000a00 1 0 a 0 00000000 0  0 00000000 1 00000a00 0 00000000 00000000 0 0 0 0 a
0 0 00000000 00000b00 1 0 b 0 00000000 0  0 00000000 1 00000b00 0 00000000 00000000 0 0 0 0 b
0 0 00000000 00000c00 1 0 c 0 00000000 0  0 00000000 1 00000c00 0 00000000 00000000 0 0 0 0 c
0 0 00000000 00000d00 1 0 d 0 00000000 0  0 00000000 1 00000d00 0 00000000 00000000 0 0 0 0 d
0 0 00000000 00000e00 1 0 e 0 00000000 0  0 00000000 1 00000e00 0 00000000 00000000 0 0 0 0 e
0 0 00000000 00000f00 1 0 f 0 00000000 0  0 00000000 1 00000f00 0 00000000 00000000 0 0 0 0 f
0 0 00000000 00001000 1 0 0 0 00000000 0  0 00000000 1 00001000 0 00000000 00000000 0 0 0 0 0
0 0 00000000 00001100 1 0 1 0 00000000 0  0 00000000 1 00001100 0 00000000 00000000 0 0 0 0 1
0 0 00000000 00001200 1 0 2 0 00000000 0  0 00000000 1 00001200 0 00000000 00000000 0 0 0 0 2
0 0 00000000 00001300 1 0 3 0 00000000 0  0 00000000 1 00001300 0 00000000 00000000 0 0 0 0 3
0 0 00000000 00001400 1 0 4 0 00000000 0  0 00000000 1 00001400 0 00000000 00000000 0 0 0 0 4
0 0 00000000 00001500 1 0 5 0 00000000 0  0 00000000 1 00001500 0 00000000 00000000 0 0 0 0 5
0 0 00000000 00001600 1 0 6 0 00000000 0  0 00000000 1 00001600 0 00000000 00000000 0 0 0 0 6
0 0 00000000 00001700 1 0 7 0 00000000 0  0 00000000 1 00001700 0 00000000 00000000 0 0 0 0 7
0 0 00000000 00001800 1 0 8 0 00000000 0  0 00000000 1 00001800 0 00000000 00000000 0 0 0 0 8
0 0 00000000 00001900 1 0 9 0 00000000 0  0 00000000 1 00001900 0 00000000 00000000 0 0 0 0 9
0 0 00000000 00001a00 1 0 a 0 00000000 0  0 00000000 1 00001a00 0 00000000 00000000 0 0 0 0 a
0 0 00000000 00001b00 1 0 b 0 00000000 0  0 00000000 1 00001b00 0 00000000 00000000 0 0 0 0 b
0 0 00000000 00001c00 1 0 c 0 00000000 0  0 00000000 1 00001c00 0 00000000 00000000 0 0 0 0 c
0 0 00000000 00001d00 1 0 d 0 00000000 0  0 00000000 1 00001d00 0 00000000 00000000 0 0 0 0 d
0 0 00000000 00001e00 1 0 e 0 00000000 0  0 00000000 1 00001e00 0 00000000 00000000 0 0 0 0 e
0 0 00000000 00001f00 1 0 f 0 00000000 0  0 00000000 1 00001f00 0 00000000 00000000 0 0 0 0 f
0 0 00000000 00000000 0 0 0 0 00000000 0  0 00000000 0 00000000 0 00000000 00000000 0 0 0 0 0

// File: verif/tb_rv_retire.sv
/* Retire stage testbench
 * Replays the vector file with its expected outputs,
 * then random aligned loads checked against a local alignment model
 */
`timescale 1ns/100ps
`default_nettype none

module tb_rv_retire;
    import rv_retire_pkg::*;

    localparam int TAG_WIDTH    = 4;
    localparam int NUM_FIELDS   = 22;           // 10 inputs, 12 expected outputs
    localparam int RESET_CYCLES = 5;
    localparam int RESET_LIMIT  = 10;           // Cycles allowed for the tag to clear
    localparam int RANDOM_LOADS = 200;
    localparam int MAX_CYCLES   = 2000;         // Watchdog for the whole run

    typedef logic [TAG_WIDTH-1:0] tag_t;

    logic      clk;
    logic      reset;
    logic      exception;
    op_t       op;
    word_t     result0;
    word_t     result1;
    logic      jump;
    logic      we;
    tag_t      tag_in;
    byte_en_t  we_mem_in;
    word_t     data_in;
    logic      interrupt_pending;
    logic      reg_we;
    word_t     wr_data;
    logic      jump_out;
    word_t     new_pc;
    word_t     write_address;
    word_t     data_out;
    byte_en_t  write;
    tag_t      curr_retire_tag;
    logic      raise_exception;
    exc_code_t exception_code;
    logic      machine_return;
    logic      interrupt_ack;

    logic [31:0] fields [NUM_FIELDS];           // One parsed vector line
    op_t load_ops [5] = '{OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};

    rv_retire_top #(
        .TAG_WIDTH (TAG_WIDTH)
    ) i_dut (
        .clk               (clk),
        .reset             (reset),
        .exception         (exception),
        .op                (op),
        .result0           (result0),
        .result1           (result1),
        .jump              (jump),
        .we                (we),
        .tag_in            (tag_in),
        .we_mem_in         (we_mem_in),
        .data_in           (data_in),
        .interrupt_pending (interrupt_pending),
        .reg_we            (reg_we),
        .wr_data           (wr_data),
        .jump_out          (jump_out),
        .new_pc            (new_pc),
        .write_address     (write_address),
        .data_out          (data_out),
        .write             (write),
        .curr_retire_tag   (curr_retire_tag),
        .raise_exception   (raise_exception),
        .exception_code    (exception_code),
        .machine_return    (machine_return),
        .interrupt_ack     (interrupt_ack)
    );

    always #5 clk = ~clk;                       // 10 ns period

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("error at %0t: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_byte_en(input string name, input byte_en_t got, input byte_en_t exp);
        if (got !== exp) begin
            fail_run($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_exc(input string name, input exc_code_t got, input exc_code_t exp);
        if (got !== exp) begin
            fail_run($sformatf("error at %0t: %s is %0d, expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic check_tag(input string name, input tag_t got, input tag_t exp);
        if (got !== exp) begin
            fail_run($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    // Shift the addressed lane down, then mask or sign-extend it
    function automatic word_t expected_load(op_t kind, logic [1:0] addr, word_t word);
        word_t shifted;
        shifted = word >> (8 * addr);
        case (kind)
            OP_LB:   return 32'($signed(shifted[7:0]));
            OP_LBU:  return shifted & 32'h0000_00ff;
            OP_LH:   return 32'($signed(shifted[15:0]));
            OP_LHU:  return shifted & 32'h0000_ffff;
            default: return word;
        endcase
    endfunction

    task automatic clear_inputs();
        exception         = 1'b0;
        op                = OP_OTHER;
        result0           = '0;
        result1           = '0;
        jump              = 1'b0;
        we                = 1'b0;
        tag_in            = '0;
        we_mem_in         = '0;
        data_in           = '0;
        interrupt_pending = 1'b0;
    endtask

    task automatic apply_vector();
        exception         = fields[0][0];
        op                = op_t'(fields[1][3:0]);
        result0           = fields[2];
        result1           = fields[3];
        jump              = fields[4][0];
        we                = fields[5][0];
        tag_in            = fields[6][TAG_WIDTH-1:0];
        we_mem_in         = fields[7][3:0];
        data_in           = fields[8];
        interrupt_pending = fields[9][0];
    endtask

    task automatic check_vector();
        check_bit("reg_we", reg_we, fields[10][0]);
        check_word("wr_data", wr_data, fields[11]);
        check_bit("jump_out", jump_out, fields[12][0]);
        check_word("new_pc", new_pc, fields[13]);
        check_byte_en("write", write, fields[14][3:0]);
        check_word("write_address", write_address, fields[15]);
        check_word("data_out", data_out, fields[16]);
        check_bit("raise_exception", raise_exception, fields[17][0]);
        check_exc("exception_code", exception_code, exc_code_t'(fields[18][3:0]));
        check_bit("machine_return", machine_return, fields[19][0]);
        check_bit("interrupt_ack", interrupt_ack, fields[20][0]);
        check_tag("curr_retire_tag", curr_retire_tag, fields[21][TAG_WIDTH-1:0]);
    endtask

    task automatic wait_tag_clear();
        int cycles;
        cycles = 0;
        while (curr_retire_tag !== '0) begin
            @(negedge clk);
            cycles++;
            if (cycles > RESET_LIMIT) fail_run("retire tag did not clear after reset");
        end
    endtask

    // Watchdog on the run length
    initial begin
        int cycles;
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        fail_run($sformatf("simulation did not finish within %0d cycles", MAX_CYCLES));
    end

    initial begin
        int         fd;
        int         count;
        int         vectors;
        string      line;
        tag_t       exp_tag;
        op_t        kind;
        logic [1:0] addr;
        word_t      word;
        logic       wb;
        void'($urandom(49321));                 // Single seed for the run
        clk   = 1'b0;
        reset = 1'b1;
        clear_inputs();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        wait_tag_clear();

        fd = $fopen("verif/retire_vectors.txt", "r");
        if (fd == 0) fail_run("could not open the vector file verif/retire_vectors.txt");
        vectors = 0;
        exp_tag = '0;
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line.getc(0) == "#") continue;     // Comment or blank
            count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                fields[0], fields[1], fields[2], fields[3], fields[4], fields[5], fields[6],
                fields[7], fields[8], fields[9], fields[10], fields[11], fields[12],
                fields[13], fields[14], fields[15], fields[16], fields[17], fields[18],
                fields[19], fields[20], fields[21]);
            if (count != NUM_FIELDS) begin
                fail_run($sformatf("vector %0d has %0d columns instead of %0d",
                    vectors + 1, count, NUM_FIELDS));
            end
            @(negedge clk);
            apply_vector();
            #4;                                 // Just before the next rising edge
            check_vector();
            exp_tag = fields[21][TAG_WIDTH-1:0]; // Tag left by the idle last line
            vectors++;
        end
        $fclose(fd);
        if (vectors == 0) fail_run("the vector file holds no vectors");

        // Random live loads without control events keep the tag in place
        for (int i = 0; i < RANDOM_LOADS; i++) begin
            kind = load_ops[$urandom_range(4, 0)];
            addr = 2'($urandom_range(3, 0));
            if (kind inside {OP_LH, OP_LHU}) addr[0] = 1'b0;       // Halves stay aligned
            word = $urandom();
            wb   = 1'($urandom_range(1, 0));
            @(negedge clk);
            clear_inputs();
            op      = kind;
            result0 = $urandom();
            result1 = ($urandom() & 32'hffff_fffc) | {30'd0, addr};
            data_in = word;
            we      = wb;
            tag_in  = exp_tag;
            #4;
            check_word("wr_data", wr_data, expected_load(kind, addr, word));
            check_bit("reg_we", reg_we, wb);
            check_byte_en("write", write, '0);
            check_bit("jump_out", jump_out, 1'b0);
            check_bit("raise_exception", raise_exception, 1'b0);
            check_tag("curr_retire_tag", curr_retire_tag, exp_tag);
        end

        @(negedge clk);
        clear_inputs();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
